// File: Bender.yml
package:
  name: lockstep_checker

sources:
  - logic/lockstep_pkg.sv
  - logic/lockstep_reset_seq.sv
  - logic/shadow_input_stage.sv
  - logic/core_decode.sv
  - logic/core_execute.sv
  - logic/core_result.sv
  - logic/shadow_core.sv
  - logic/lockstep_compare.sv
  - logic/lockstep_top.sv
  - target: simulation
    files:
      - test/lockstep_model.sv
      - test/lockstep_tb.sv

// File: lockstep_checker.f
logic/lockstep_pkg.sv
logic/lockstep_reset_seq.sv
logic/shadow_input_stage.sv
logic/core_decode.sv
logic/core_execute.sv
logic/core_result.sv
logic/shadow_core.sv
logic/lockstep_compare.sv
logic/lockstep_top.sv
test/lockstep_model.sv
test/lockstep_tb.sv

// File: logic/core_decode.sv
`timescale 1ns/100ps

module core_decode (
  input  logic                              instr_valid_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     instr_i,
  input  logic                              rdata_valid_i,
  output lockstep_pkg::opcode_e             opcode_o,
  output logic [lockstep_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [lockstep_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [lockstep_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [lockstep_pkg::IMM_W-1:0]      imm_o,
  output logic                              wr_en_o,
  output logic                              illegal_o
);

  import lockstep_pkg::*;

  logic [OPC_MSB-OPC_LSB:0] opc_raw;

  assign opc_raw  = instr_i[OPC_MSB:OPC_LSB];
  assign opcode_o = opcode_e'(opc_raw);
  assign rd_o     = instr_i[RD_LSB+:REG_ADDR_W];
  assign rs1_o    = instr_i[RS1_LSB+:REG_ADDR_W];
  assign rs2_o    = instr_i[RS2_LSB+:REG_ADDR_W];
  assign imm_o    = instr_i[IMM_W-1:0];

  // Everything above LOAD is outside the opcode map
  assign illegal_o = instr_valid_i & (opc_raw > OP_LOAD);

  always_comb begin
    wr_en_o = 1'b0;
    case (opcode_o)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: wr_en_o = instr_valid_i;
      // LOAD only writes when the read data actually arrived
      OP_LOAD: wr_en_o = instr_valid_i & rdata_valid_i;
      default: wr_en_o = 1'b0;
    endcase
  end

endmodule

// File: logic/core_execute.sv
`timescale 1ns/100ps

module core_execute (
  input  lockstep_pkg::opcode_e         opcode_i,
  input  logic [lockstep_pkg::IMM_W-1:0]  imm_i,
  input  logic [lockstep_pkg::DATA_W-1:0] rs1_data_i,
  input  logic [lockstep_pkg::DATA_W-1:0] rs2_data_i,
  input  logic [lockstep_pkg::DATA_W-1:0] rdata_i,
  output logic [lockstep_pkg::DATA_W-1:0] result_o
);

  import lockstep_pkg::*;

  logic [DATA_W-1:0] imm_ext;

  // Zero extension of the immediate
  assign imm_ext = {{(DATA_W - IMM_W){1'b0}}, imm_i};

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (opcode_i)
      OP_ADD:  result_o = rs1_data_i + rs2_data_i;
      OP_SUB:  result_o = rs1_data_i - rs2_data_i;
      OP_AND:  result_o = rs1_data_i & rs2_data_i;
      OP_OR:   result_o = rs1_data_i | rs2_data_i;
      OP_XOR:  result_o = rs1_data_i ^ rs2_data_i;
      OP_ADDI: result_o = rs1_data_i + imm_ext;
      OP_LOAD: result_o = rdata_i;
      // NOP and illegal opcodes produce nothing
      default: result_o = '0;
    endcase
  end

endmodule

// File: logic/core_result.sv
`timescale 1ns/100ps

module core_result (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [lockstep_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [lockstep_pkg::REG_ADDR_W-1:0] rs2_i,
  output logic [lockstep_pkg::DATA_W-1:0]     rs1_data_o,
  output logic [lockstep_pkg::DATA_W-1:0]     rs2_data_o,
  input  logic                              wr_en_i,
  input  logic [lockstep_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     result_i,
  input  logic                              illegal_i,
  output logic                              wb_we_o,
  output logic [lockstep_pkg::REG_ADDR_W-1:0] wb_addr_o,
  output logic [lockstep_pkg::DATA_W-1:0]     wb_data_o,
  output logic                              illegal_o
);

  import lockstep_pkg::*;

  logic [DATA_W-1:0]     regs_q [NUM_REGS];
  logic                  wb_we_q;
  logic [REG_ADDR_W-1:0] wb_addr_q;
  logic [DATA_W-1:0]     wb_data_q;
  logic                  illegal_q;

  // Combinational register reads
  assign rs1_data_o = regs_q[rs1_i];
  assign rs2_data_o = regs_q[rs2_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
      wb_we_q   <= 1'b0;
      wb_addr_q <= '0;
      wb_data_q <= '0;
      illegal_q <= 1'b0;
    end else begin
      if (wr_en_i) begin
        regs_q[rd_i] <= result_i;
      end
      // Address and data are zero on cycles without a write
      wb_we_q   <= wr_en_i;
      wb_addr_q <= wr_en_i ? rd_i : '0;
      wb_data_q <= wr_en_i ? result_i : '0;
      illegal_q <= illegal_i;
    end
  end

  assign wb_we_o   = wb_we_q;
  assign wb_addr_o = wb_addr_q;
  assign wb_data_o = wb_data_q;
  assign illegal_o = illegal_q;

endmodule

// File: logic/lockstep_compare.sv
`timescale 1ns/100ps

module lockstep_compare (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              enable_cmp_i,
  input  logic                              main_wb_we_i,
  input  logic [lockstep_pkg::REG_ADDR_W-1:0] main_wb_addr_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     main_wb_data_i,
  input  logic                              shadow_wb_we_i,
  input  logic [lockstep_pkg::REG_ADDR_W-1:0] shadow_wb_addr_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     shadow_wb_data_i,
  input  logic                              shadow_illegal_i,
  input  logic                              bus_intg_err_i,
  output logic                              alert_major_o
);

  import lockstep_pkg::*;

  // Index 0 is the oldest main write-back
  logic [OUTPUTS_OFFSET-1:0] main_we_q;
  logic [REG_ADDR_W-1:0]     main_addr_q [OUTPUTS_OFFSET];
  logic [DATA_W-1:0]         main_data_q [OUTPUTS_OFFSET];
  logic                      shadow_we_q;
  logic [REG_ADDR_W-1:0]     shadow_addr_q;
  logic [DATA_W-1:0]         shadow_data_q;
  logic                      mismatch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_we_q     <= '0;
      shadow_we_q   <= 1'b0;
      shadow_addr_q <= '0;
      shadow_data_q <= '0;
      for (int i = 0; i < OUTPUTS_OFFSET; i++) begin
        main_addr_q[i] <= '0;
        main_data_q[i] <= '0;
      end
    end else begin
      main_we_q <= {main_wb_we_i, main_we_q[OUTPUTS_OFFSET-1:1]};
      for (int i = 0; i < OUTPUTS_OFFSET - 1; i++) begin
        main_addr_q[i] <= main_addr_q[i+1];
        main_data_q[i] <= main_data_q[i+1];
      end
      main_addr_q[OUTPUTS_OFFSET-1] <= main_wb_addr_i;
      main_data_q[OUTPUTS_OFFSET-1] <= main_wb_data_i;
      // Shadow output register
      shadow_we_q   <= shadow_wb_we_i;
      shadow_addr_q <= shadow_wb_addr_i;
      shadow_data_q <= shadow_wb_data_i;
    end
  end

  assign mismatch = enable_cmp_i &
                    ({shadow_we_q, shadow_addr_q, shadow_data_q} !=
                     {main_we_q[0], main_addr_q[0], main_data_q[0]});

  assign alert_major_o = mismatch | shadow_illegal_i | bus_intg_err_i;

endmodule

// File: logic/lockstep_pkg.sv
package lockstep_pkg;

  //////////////////////////////////////////////////
  // Widths and lockstep offsets
  //////////////////////////////////////////////////

  localparam int unsigned DATA_W     = 32;
  localparam int unsigned INTG_W     = 7;
  localparam int unsigned REG_ADDR_W = 3;
  localparam int unsigned NUM_REGS   = 8;

  // Shadow core lags the main core by this many cycles
  localparam int unsigned LOCKSTEP_OFFSET = 2;
  // Extra stage covers the shadow output register
  localparam int unsigned OUTPUTS_OFFSET  = LOCKSTEP_OFFSET + 1;
  localparam int unsigned OFFSET_CNT_W    = $clog2(LOCKSTEP_OFFSET);

  //////////////////////////////////////////////////
  // Instruction format
  //////////////////////////////////////////////////

  localparam int unsigned OPC_MSB = 31;
  localparam int unsigned OPC_LSB = 28;
  localparam int unsigned RD_LSB  = 25;
  localparam int unsigned RS1_LSB = 22;
  localparam int unsigned RS2_LSB = 19;
  // Immediate sits in the low bits and is zero-extended
  localparam int unsigned IMM_W   = 16;

  typedef enum logic [OPC_MSB-OPC_LSB:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_ADDI = 4'd6,
    OP_LOAD = 4'd7
  } opcode_e;

  //////////////////////////////////////////////////
  // Bus integrity code
  //////////////////////////////////////////////////

  localparam logic [INTG_W-1:0] INTG_INV_MASK = 7'b0101010;

  // Interleaved parity over bit index modulo INTG_W, then inverted by the mask
  function automatic logic [INTG_W-1:0] intg_bits(logic [DATA_W-1:0] data);
    logic [INTG_W-1:0] chk;
    chk = '0;
    for (int i = 0; i < DATA_W; i++) begin
      chk[i % INTG_W] = chk[i % INTG_W] ^ data[i];
    end
    return chk ^ INTG_INV_MASK;
  endfunction

endpackage

// File: logic/lockstep_reset_seq.sv
`timescale 1ns/100ps

module lockstep_reset_seq (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic enable_cmp_o
);

  import lockstep_pkg::*;

  logic [OFFSET_CNT_W-1:0] offset_cnt_d, offset_cnt_q;
  logic                    rst_shadow_set_d, rst_shadow_set_q;
  logic                    enable_cmp_q;

  // Counter stops once the offset is reached
  assign rst_shadow_set_d = (offset_cnt_q == OFFSET_CNT_W'(LOCKSTEP_OFFSET - 1));
  assign offset_cnt_d     = rst_shadow_set_d ? offset_cnt_q
                                             : offset_cnt_q + OFFSET_CNT_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_cnt_q     <= '0;
      rst_shadow_set_q <= 1'b0;
      enable_cmp_q     <= 1'b0;
    end else begin
      offset_cnt_q     <= offset_cnt_d;
      rst_shadow_set_q <= rst_shadow_set_d;
      // Compare starts one cycle after the shadow leaves reset
      enable_cmp_q     <= rst_shadow_set_q;
    end
  end

  // Shadow reset comes straight from a flop so it is glitch free
  assign rst_shadow_no = rst_shadow_set_q;
  assign enable_cmp_o  = enable_cmp_q;

endmodule

// File: logic/lockstep_top.sv
`timescale 1ns/100ps

module lockstep_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              instr_valid_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     instr_i,
  input  logic [lockstep_pkg::INTG_W-1:0]     instr_intg_i,
  input  logic                              rdata_valid_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     rdata_i,
  input  logic [lockstep_pkg::INTG_W-1:0]     rdata_intg_i,
  input  logic                              main_wb_we_i,
  input  logic [lockstep_pkg::REG_ADDR_W-1:0] main_wb_addr_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     main_wb_data_i,
  output logic                              alert_major_o
);

  import lockstep_pkg::*;

  logic                  rst_shadow_n;
  logic                  enable_cmp;
  logic                  shadow_instr_valid;
  logic [DATA_W-1:0]     shadow_instr;
  logic                  shadow_rdata_valid;
  logic [DATA_W-1:0]     shadow_rdata;
  logic                  bus_intg_err;
  logic                  shadow_wb_we;
  logic [REG_ADDR_W-1:0] shadow_wb_addr;
  logic [DATA_W-1:0]     shadow_wb_data;
  logic                  shadow_illegal;

  lockstep_reset_seq u_reset_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rst_shadow_no(rst_shadow_n),
    .enable_cmp_o (enable_cmp)
  );

  shadow_input_stage u_input_stage (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .instr_i             (instr_i),
    .instr_intg_i        (instr_intg_i),
    .rdata_valid_i       (rdata_valid_i),
    .rdata_i             (rdata_i),
    .rdata_intg_i        (rdata_intg_i),
    .shadow_instr_valid_o(shadow_instr_valid),
    .shadow_instr_o      (shadow_instr),
    .shadow_rdata_valid_o(shadow_rdata_valid),
    .shadow_rdata_o      (shadow_rdata),
    .bus_intg_err_o      (bus_intg_err)
  );

  // Replica core runs on the sequenced reset
  shadow_core u_shadow_core (
    .clk_i        (clk_i),
    .rst_ni       (rst_shadow_n),
    .instr_valid_i(shadow_instr_valid),
    .instr_i      (shadow_instr),
    .rdata_valid_i(shadow_rdata_valid),
    .rdata_i      (shadow_rdata),
    .wb_we_o      (shadow_wb_we),
    .wb_addr_o    (shadow_wb_addr),
    .wb_data_o    (shadow_wb_data),
    .illegal_o    (shadow_illegal)
  );

  lockstep_compare u_compare (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .enable_cmp_i    (enable_cmp),
    .main_wb_we_i    (main_wb_we_i),
    .main_wb_addr_i  (main_wb_addr_i),
    .main_wb_data_i  (main_wb_data_i),
    .shadow_wb_we_i  (shadow_wb_we),
    .shadow_wb_addr_i(shadow_wb_addr),
    .shadow_wb_data_i(shadow_wb_data),
    .shadow_illegal_i(shadow_illegal),
    .bus_intg_err_i  (bus_intg_err),
    .alert_major_o   (alert_major_o)
  );

endmodule

// File: logic/shadow_core.sv
`timescale 1ns/100ps

module shadow_core (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              instr_valid_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     instr_i,
  input  logic                              rdata_valid_i,
  input  logic [lockstep_pkg::DATA_W-1:0]     rdata_i,
  output logic                              wb_we_o,
  output logic [lockstep_pkg::REG_ADDR_W-1:0] wb_addr_o,
  output logic [lockstep_pkg::DATA_W-1:0]     wb_data_o,
  output logic                              illegal_o
);

  import lockstep_pkg::*;

  opcode_e               opcode;
  logic [REG_ADDR_W-1:0] rd, rs1, rs2;
  logic [IMM_W-1:0]      imm;
  logic                  wr_en;
  logic                  illegal;
  logic [DATA_W-1:0]     rs1_data, rs2_data;
  logic [DATA_W-1:0]     result;

  core_decode u_decode (
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .rdata_valid_i(rdata_valid_i),
    .opcode_o     (opcode),
    .rd_o         (rd),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .imm_o        (imm),
    .wr_en_o      (wr_en),
    .illegal_o    (illegal)
  );

  core_execute u_execute (
    .opcode_i  (opcode),
    .imm_i     (imm),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .rdata_i   (rdata_i),
    .result_o  (result)
  );

  // Register file and write-back flops
  core_result u_result (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wr_en_i   (wr_en),
    .rd_i      (rd),
    .result_i  (result),
    .illegal_i (illegal),
    .wb_we_o   (wb_we_o),
    .wb_addr_o (wb_addr_o),
    .wb_data_o (wb_data_o),
    .illegal_o (illegal_o)
  );

endmodule

// File: logic/shadow_input_stage.sv
`timescale 1ns/100ps

module shadow_input_stage (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          instr_valid_i,
  input  logic [lockstep_pkg::DATA_W-1:0] instr_i,
  input  logic [lockstep_pkg::INTG_W-1:0] instr_intg_i,
  input  logic                          rdata_valid_i,
  input  logic [lockstep_pkg::DATA_W-1:0] rdata_i,
  input  logic [lockstep_pkg::INTG_W-1:0] rdata_intg_i,
  output logic                          shadow_instr_valid_o,
  output logic [lockstep_pkg::DATA_W-1:0] shadow_instr_o,
  output logic                          shadow_rdata_valid_o,
  output logic [lockstep_pkg::DATA_W-1:0] shadow_rdata_o,
  output logic                          bus_intg_err_o
);

  import lockstep_pkg::*;

  // Index LOCKSTEP_OFFSET-1 is the newest stage, index 0 feeds the shadow
  logic [LOCKSTEP_OFFSET-1:0] instr_valid_q;
  logic [DATA_W-1:0]          instr_q [LOCKSTEP_OFFSET];
  logic [LOCKSTEP_OFFSET-1:0] rdata_valid_q;
  logic [DATA_W-1:0]          rdata_q [LOCKSTEP_OFFSET];
  logic [INTG_W-1:0]          instr_intg_q, rdata_intg_q;
  logic                       instr_intg_err, rdata_intg_err;

  //////////////////////////////////////////////////
  // Input delay line
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_q <= '0;
      rdata_valid_q <= '0;
      instr_intg_q  <= '0;
      rdata_intg_q  <= '0;
      for (int i = 0; i < LOCKSTEP_OFFSET; i++) begin
        instr_q[i] <= '0;
        rdata_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < LOCKSTEP_OFFSET - 1; i++) begin
        instr_valid_q[i] <= instr_valid_q[i+1];
        instr_q[i]       <= instr_q[i+1];
        rdata_valid_q[i] <= rdata_valid_q[i+1];
        rdata_q[i]       <= rdata_q[i+1];
      end
      instr_valid_q[LOCKSTEP_OFFSET-1] <= instr_valid_i;
      instr_q[LOCKSTEP_OFFSET-1]       <= instr_i;
      rdata_valid_q[LOCKSTEP_OFFSET-1] <= rdata_valid_i;
      rdata_q[LOCKSTEP_OFFSET-1]       <= rdata_i;
      // Check bits only need one stage, they are checked right away
      instr_intg_q <= instr_intg_i;
      rdata_intg_q <= rdata_intg_i;
    end
  end

  assign shadow_instr_valid_o = instr_valid_q[0];
  assign shadow_instr_o       = instr_q[0];
  assign shadow_rdata_valid_o = rdata_valid_q[0];
  assign shadow_rdata_o       = rdata_q[0];

  //////////////////////////////////////////////////
  // Bus integrity check
  //////////////////////////////////////////////////

  // Words without a valid carry no meaning and are not checked
  assign instr_intg_err = instr_valid_q[LOCKSTEP_OFFSET-1] &
                          (instr_intg_q != intg_bits(instr_q[LOCKSTEP_OFFSET-1]));
  assign rdata_intg_err = rdata_valid_q[LOCKSTEP_OFFSET-1] &
                          (rdata_intg_q != intg_bits(rdata_q[LOCKSTEP_OFFSET-1]));

  assign bus_intg_err_o = instr_intg_err | rdata_intg_err;

endmodule

// File: test/lockstep_model.sv
`timescale 1ns/100ps

module lockstep_model;

  import lockstep_pkg::*;

  logic [DATA_W-1:0]     regs [NUM_REGS];
  // Write-back of the last executed instruction, as the main core presents it
  logic                  wb_we;
  logic [REG_ADDR_W-1:0] wb_addr;
  logic [DATA_W-1:0]     wb_data;

  // Cycle numbers in which the alert has to be high
  int unsigned           alert_cycles_q[$];
  int unsigned           check_cnt = 0;
  int unsigned           error_cnt = 0;

  task automatic reset_core();
    for (int i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
    end
    wb_we   = 1'b0;
    wb_addr = '0;
    wb_data = '0;
  endtask

  // Parity of every seventh bit, then inverted by the mask
  function automatic logic [INTG_W-1:0] encode_intg(input logic [DATA_W-1:0] word);
    logic [INTG_W-1:0] chk;
    chk = '0;
    for (int b = 0; b < DATA_W; b++) begin
      chk[b % INTG_W] = chk[b % INTG_W] ^ word[b];
    end
    return chk ^ INTG_INV_MASK;
  endfunction

  task automatic execute(input logic valid, input logic [DATA_W-1:0] instr,
                         input logic rdata_valid, input logic [DATA_W-1:0] rdata);
    logic [DATA_W-1:0]     op_a;
    logic [DATA_W-1:0]     op_b;
    logic [DATA_W-1:0]     imm;
    logic [DATA_W-1:0]     res;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    op_a = regs[instr[RS1_LSB+:REG_ADDR_W]];
    op_b = regs[instr[RS2_LSB+:REG_ADDR_W]];
    rd   = instr[RD_LSB+:REG_ADDR_W];
    imm  = '0;
    imm[IMM_W-1:0] = instr[IMM_W-1:0];
    we   = valid;
    res  = '0;
    case (instr[OPC_MSB:OPC_LSB])
      OP_ADD:  res = op_a + op_b;
      OP_SUB:  res = op_a - op_b;
      OP_AND:  res = op_a & op_b;
      OP_OR:   res = op_a | op_b;
      OP_XOR:  res = op_a ^ op_b;
      OP_ADDI: res = op_a + imm;
      OP_LOAD: begin
        we  = valid & rdata_valid;
        res = we ? rdata : '0;
      end
      default: we = 1'b0;
    endcase
    if (we) begin
      regs[rd] = res;
    end
    wb_we   = we;
    wb_addr = we ? rd : '0;
    wb_data = we ? res : '0;
  endtask

  task automatic expect_alert(input int unsigned cyc);
    alert_cycles_q.push_back(cyc);
  endtask

  // Due entries leave the queue
  task automatic take_expected(input int unsigned cyc, output logic due);
    due = 1'b0;
    for (int i = alert_cycles_q.size() - 1; i >= 0; i--) begin
      if (alert_cycles_q[i] <= cyc) begin
        if (alert_cycles_q[i] == cyc) begin
          due = 1'b1;
        end
        alert_cycles_q.delete(i);
      end
    end
  endtask

  task automatic check_alert(input logic actual, input logic expected, input int unsigned cyc);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("MISMATCH at %0t: alert_major_o is %b, expected %b in cycle %0d",
               $time, actual, expected, cyc);
    end
  endtask

endmodule

// File: test/lockstep_tb.sv
`timescale 1ns/100ps

module lockstep_tb;

  import lockstep_pkg::*;

  localparam int unsigned CLK_PERIOD  = 100;
  localparam int unsigned CLEAN_LEN   = 500;
  localparam int unsigned FAULT_LEN   = 40;
  localparam int unsigned INTG_LEN    = 24;
  localparam int unsigned ILLEGAL_LEN = 60;
  localparam int unsigned STARTUP_LEN = 30;
  localparam int unsigned FLUSH_LEN   = 6;
  // Two resets of two cycles and a flush after each of the five tests
  localparam int unsigned TOTAL_CYCLES = 4 + CLEAN_LEN + FAULT_LEN + INTG_LEN + ILLEGAL_LEN
                                       + STARTUP_LEN + 5 * FLUSH_LEN;
  localparam int unsigned MARGIN_CYCLES = 50;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_valid_i;
  logic [DATA_W-1:0]     instr_i;
  logic [INTG_W-1:0]     instr_intg_i;
  logic                  rdata_valid_i;
  logic [DATA_W-1:0]     rdata_i;
  logic [INTG_W-1:0]     rdata_intg_i;
  logic                  main_wb_we_i;
  logic [REG_ADDR_W-1:0] main_wb_addr_i;
  logic [DATA_W-1:0]     main_wb_data_i;
  logic                  alert_major_o;

  int                    seed;
  int unsigned           cyc;
  int unsigned           tests_failed;
  int unsigned           errs_before;

  lockstep_top u_lockstep_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_intg_i  (instr_intg_i),
    .rdata_valid_i (rdata_valid_i),
    .rdata_i       (rdata_i),
    .rdata_intg_i  (rdata_intg_i),
    .main_wb_we_i  (main_wb_we_i),
    .main_wb_addr_i(main_wb_addr_i),
    .main_wb_data_i(main_wb_data_i),
    .alert_major_o (alert_major_o)
  );

  // Main core model and expected alerts
  lockstep_model u_model ();

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN_CYCLES));
    $display("Timeout: the tests did not finish within %0d cycles",
             TOTAL_CYCLES + MARGIN_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    w = $random(seed);
    return w;
  endfunction

  // Clearing the opcode MSB keeps it within 0 to 7
  function automatic logic [DATA_W-1:0] rand_legal_instr();
    logic [DATA_W-1:0] w;
    w = rand_word();
    w[OPC_MSB] = 1'b0;
    return w;
  endfunction

  // Alert does not depend on the inputs, so it is stable at the falling edge
  task automatic next_cycle();
    logic due;
    @(negedge clk_i);
    cyc++;
    u_model.take_expected(cyc, due);
    u_model.check_alert(alert_major_o, due, cyc);
  endtask

  task automatic drive_cycle(input logic valid, input logic [DATA_W-1:0] instr,
                             input logic rvalid, input logic [DATA_W-1:0] rdata,
                             input logic [INTG_W-1:0] instr_flip,
                             input logic [INTG_W-1:0] rdata_flip,
                             input logic [DATA_W-1:0] wb_flip);
    next_cycle();
    rst_ni         = 1'b1;
    main_wb_we_i   = u_model.wb_we;
    main_wb_addr_i = u_model.wb_addr;
    main_wb_data_i = u_model.wb_data ^ wb_flip;
    instr_valid_i  = valid;
    instr_i        = instr;
    instr_intg_i   = u_model.encode_intg(instr) ^ instr_flip;
    rdata_valid_i  = rvalid;
    rdata_i        = rdata;
    rdata_intg_i   = u_model.encode_intg(rdata) ^ rdata_flip;
    u_model.execute(valid, instr, rvalid, rdata);
    // Integrity errors show one cycle later, illegal and output faults three
    if ((valid && instr_flip != '0) || (rvalid && rdata_flip != '0)) begin
      u_model.expect_alert(cyc + 1);
    end
    if ((valid && instr[OPC_MSB]) || wb_flip != '0) begin
      u_model.expect_alert(cyc + 3);
    end
  endtask

  task automatic random_cycle();
    logic [DATA_W-1:0] ctl;
    ctl = rand_word();
    drive_cycle(ctl[2:0] != 3'b000, rand_legal_instr(), ctl[3], rand_word(), '0, '0, '0);
  endtask

  // LOAD half of the time, read data valid or not
  task automatic load_cycle(input logic illegal);
    logic [DATA_W-1:0] ctl;
    logic [DATA_W-1:0] instr;
    ctl   = rand_word();
    instr = rand_legal_instr();
    if (ctl[0]) begin
      instr[OPC_MSB:OPC_LSB] = OP_LOAD;
    end
    instr[OPC_MSB] = illegal;
    drive_cycle(1'b1, instr, ctl[1], rand_word(), '0, '0, '0);
  endtask

  task automatic intg_case(input logic on_instr, input logic valid);
    logic [INTG_W-1:0] flip;
    logic [DATA_W-1:0] ctl;
    flip = '0;
    flip[rand_word() % INTG_W] = 1'b1;
    ctl = rand_word();
    if (on_instr) begin
      drive_cycle(valid, rand_legal_instr(), ctl[1], rand_word(), flip, '0, '0);
    end else begin
      drive_cycle(ctl[0], rand_legal_instr(), valid, rand_word(), '0, flip, '0);
    end
    repeat (5) random_cycle();
  endtask

  // Two cycles of reset, from now on or from the next falling edge
  task automatic hold_reset(input logic garbage, input logic at_start);
    for (int i = 0; i < 2; i++) begin
      if (i > 0 || !at_start) begin
        next_cycle();
      end
      rst_ni         = 1'b0;
      main_wb_we_i   = garbage & rand_word() % 2;
      main_wb_addr_i = garbage ? rand_word() : '0;
      main_wb_data_i = garbage ? rand_word() : '0;
      instr_valid_i  = garbage & rand_word() % 2;
      instr_i        = garbage ? rand_word() : '0;
      instr_intg_i   = garbage ? rand_word() : '0;
      rdata_valid_i  = garbage & rand_word() % 2;
      rdata_i        = garbage ? rand_word() : '0;
      rdata_intg_i   = garbage ? rand_word() : '0;
      u_model.reset_core();
    end
  endtask

  task automatic finish_test(input string name);
    repeat (FLUSH_LEN) drive_cycle(1'b0, '0, 1'b0, '0, '0, '0, '0);
    if (u_model.error_cnt == errs_before) begin
      $display("Test %s done, no errors", name);
    end else begin
      tests_failed++;
      $display("Test %s done, %0d errors", name, u_model.error_cnt - errs_before);
    end
    errs_before = u_model.error_cnt;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [DATA_W-1:0] wb_flip;
    seed         = 8;
    cyc          = 0;
    tests_failed = 0;
    errs_before  = 0;
    hold_reset(1'b0, 1'b1);

    repeat (CLEAN_LEN) random_cycle();
    finish_test("clean_run");

    // Single bit flip on the main write-back data
    repeat (FAULT_LEN / 2) random_cycle();
    wb_flip = '0;
    wb_flip[rand_word() % DATA_W] = 1'b1;
    drive_cycle(1'b1, rand_legal_instr(), 1'b1, rand_word(), '0, '0, wb_flip);
    repeat (FAULT_LEN / 2 - 1) random_cycle();
    finish_test("output_fault");

    intg_case(1'b1, 1'b1);
    intg_case(1'b0, 1'b1);
    intg_case(1'b1, 1'b0);
    intg_case(1'b0, 1'b0);
    finish_test("integrity");

    for (int i = 0; i < ILLEGAL_LEN; i++) begin
      if (i < 10) begin
        random_cycle();
      end else begin
        load_cycle(i == 10 || i == 35);
      end
    end
    finish_test("illegal_load");

    // Reset again with garbage on every input
    hold_reset(1'b1, 1'b0);
    repeat (STARTUP_LEN) random_cycle();
    finish_test("startup");

    $display("5 tests, %0d failed, %0d checks, %0d mismatches",
             tests_failed, u_model.check_cnt, u_model.error_cnt);
    if (tests_failed == 0 && u_model.error_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
